// ==== tpu_lite_pkg.sv ====
package tpu_lite_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int DWIDTH     = 8;    // One matrix element
    localparam int AWIDTH     = 10;   // Element address, 1024 elements
    localparam int REG_DWIDTH = 32;   // Register data
    localparam int REG_AWIDTH = 8;    // Register byte offset
    localparam int MASK_WIDTH = 32;   // Column mask, low N bits used

    ////////////////////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [REG_AWIDTH-1:0] REG_CTRL     = 8'h00;
    localparam logic [REG_AWIDTH-1:0] REG_STATUS   = 8'h04;
    localparam logic [REG_AWIDTH-1:0] REG_A_ADDR   = 8'h08;
    localparam logic [REG_AWIDTH-1:0] REG_B_ADDR   = 8'h0C;
    localparam logic [REG_AWIDTH-1:0] REG_C_ADDR   = 8'h10;
    localparam logic [REG_AWIDTH-1:0] REG_A_STRIDE = 8'h14;
    localparam logic [REG_AWIDTH-1:0] REG_B_STRIDE = 8'h18;
    localparam logic [REG_AWIDTH-1:0] REG_C_STRIDE = 8'h1C;
    localparam logic [REG_AWIDTH-1:0] REG_COL_MASK = 8'h20;

    // Bit positions inside CTRL and STATUS
    localparam int CTRL_START_BIT  = 0;   // Write 1 to launch
    localparam int STATUS_BUSY_BIT = 0;   // Live engine state
    localparam int STATUS_DONE_BIT = 1;   // Sticky, write 1 to clear

    ////////////////////////////////////////////////////////////////////////////
    // Structures between register block and sequencer
    ////////////////////////////////////////////////////////////////////////////

    // Strides count elements between consecutive rows
    typedef struct packed {
        logic [AWIDTH-1:0]     a_addr;     // Base of A
        logic [AWIDTH-1:0]     b_addr;     // Base of B
        logic [AWIDTH-1:0]     c_addr;     // Base of C
        logic [AWIDTH-1:0]     a_stride;
        logic [AWIDTH-1:0]     b_stride;
        logic [AWIDTH-1:0]     c_stride;
        logic [MASK_WIDTH-1:0] col_mask;   // Per column write enable for C
    } mm_cfg_t;

    typedef struct packed {
        logic busy;         // High for the whole run
        logic done_pulse;   // One cycle, last C row write
    } mm_status_t;

endpackage

// ==== tpu_lite_ram.sv ====
module tpu_lite_ram #(
    parameter int N = 4
) (
    input  logic                                clk,
    input  logic [tpu_lite_pkg::AWIDTH-1:0]     addr0,
    input  logic [tpu_lite_pkg::AWIDTH-1:0]     addr1,
    input  logic [N*tpu_lite_pkg::DWIDTH-1:0]   d0,
    input  logic [N*tpu_lite_pkg::DWIDTH-1:0]   d1,
    input  logic [N-1:0]                        we0,
    input  logic [N-1:0]                        we1,
    output logic [N*tpu_lite_pkg::DWIDTH-1:0]   q0,
    output logic [N*tpu_lite_pkg::DWIDTH-1:0]   q1
);
    import tpu_lite_pkg::*;

    localparam int DEPTH = 1 << AWIDTH;

    logic [DWIDTH-1:0] mem [DEPTH];   // Element addressed storage

    // Each port sees a row of N consecutive elements starting at its address.
    // The index arithmetic stays AWIDTH wide so rows wrap around the top.
    always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
            q0[i*DWIDTH +: DWIDTH] <= mem[addr0 + AWIDTH'(i)];   // Old data on collision
            q1[i*DWIDTH +: DWIDTH] <= mem[addr1 + AWIDTH'(i)];
        end

        for (int i = 0; i < N; i++) begin
            if (we0[i]) begin
                mem[addr0 + AWIDTH'(i)] <= d0[i*DWIDTH +: DWIDTH];
            end
        end

        for (int i = 0; i < N; i++) begin
            if (we1[i]) begin
                mem[addr1 + AWIDTH'(i)] <= d1[i*DWIDTH +: DWIDTH];   // Own address
            end
        end
    end

endmodule

// ==== tpu_lite_regs.sv ====
module tpu_lite_regs (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  reg_wr,
    input  logic                                  reg_rd,
    input  logic [tpu_lite_pkg::REG_AWIDTH-1:0]   reg_addr,
    input  logic [tpu_lite_pkg::REG_DWIDTH-1:0]   reg_wdata,
    output logic [tpu_lite_pkg::REG_DWIDTH-1:0]   reg_rdata,
    output tpu_lite_pkg::mm_cfg_t                 cfg,
    output logic                                  start,
    input  tpu_lite_pkg::mm_status_t              status
);
    import tpu_lite_pkg::*;

    logic                  wr_ctrl;
    logic                  wr_status;
    logic                  done_sticky;
    logic [REG_DWIDTH-1:0] rd_value;

    assign wr_ctrl   = reg_wr && (reg_addr == REG_CTRL);
    assign wr_status = reg_wr && (reg_addr == REG_STATUS);

    ////////////////////////////////////////////////////////////////////////////
    // Configuration
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg <= '0;
        end else if (reg_wr) begin
            case (reg_addr)
                REG_A_ADDR:   cfg.a_addr   <= reg_wdata[AWIDTH-1:0];
                REG_B_ADDR:   cfg.b_addr   <= reg_wdata[AWIDTH-1:0];
                REG_C_ADDR:   cfg.c_addr   <= reg_wdata[AWIDTH-1:0];
                REG_A_STRIDE: cfg.a_stride <= reg_wdata[AWIDTH-1:0];
                REG_B_STRIDE: cfg.b_stride <= reg_wdata[AWIDTH-1:0];
                REG_C_STRIDE: cfg.c_stride <= reg_wdata[AWIDTH-1:0];
                REG_COL_MASK: cfg.col_mask <= reg_wdata[MASK_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Start pulse and status
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            start       <= 1'b0;
            done_sticky <= 1'b0;
        end else begin
            start <= wr_ctrl && reg_wdata[CTRL_START_BIT] && !status.busy;   // One cycle
            if (status.done_pulse) begin
                done_sticky <= 1'b1;   // Set wins over clear
            end else if (wr_status && reg_wdata[STATUS_DONE_BIT]) begin
                done_sticky <= 1'b0;
            end
        end
    end

    // Read mux, unmapped offsets fall through to zero
    always_comb begin
        rd_value = '0;
        case (reg_addr)
            REG_STATUS: begin
                rd_value[STATUS_BUSY_BIT] = status.busy;
                rd_value[STATUS_DONE_BIT] = done_sticky;
            end
            REG_A_ADDR:   rd_value[AWIDTH-1:0]     = cfg.a_addr;
            REG_B_ADDR:   rd_value[AWIDTH-1:0]     = cfg.b_addr;
            REG_C_ADDR:   rd_value[AWIDTH-1:0]     = cfg.c_addr;
            REG_A_STRIDE: rd_value[AWIDTH-1:0]     = cfg.a_stride;
            REG_B_STRIDE: rd_value[AWIDTH-1:0]     = cfg.b_stride;
            REG_C_STRIDE: rd_value[AWIDTH-1:0]     = cfg.c_stride;
            REG_COL_MASK: rd_value[MASK_WIDTH-1:0] = cfg.col_mask;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_rdata <= '0;
        end else if (reg_rd) begin
            reg_rdata <= rd_value;   // Held until the next read
        end
    end

endmodule

// ==== tpu_lite_ctrl.sv ====
module tpu_lite_ctrl #(
    parameter int N = 4
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              start,
    input  tpu_lite_pkg::mm_cfg_t             cfg,
    output tpu_lite_pkg::mm_status_t          status,
    output logic [tpu_lite_pkg::AWIDTH-1:0]   addr0,
    output logic [tpu_lite_pkg::AWIDTH-1:0]   addr1,
    output logic [N-1:0]                      we0,
    output logic                              acc_clear,
    output logic                              acc_en,
    output logic [$clog2(N)-1:0]              k_sel
);
    import tpu_lite_pkg::*;

    localparam int KW = $clog2(N);       // Row and k index
    localparam int SW = $clog2(N + 2);   // Step within a row
    localparam logic [SW-1:0] STEP_DRAIN = SW'(N);
    localparam logic [SW-1:0] STEP_WRITE = SW'(N + 1);
    localparam logic [KW-1:0] ROW_LAST   = KW'(N - 1);

    logic              busy;
    logic [KW-1:0]     row;
    logic [SW-1:0]     step;
    logic [AWIDTH-1:0] a_row_addr;
    logic [AWIDTH-1:0] b_row_addr;
    logic [AWIDTH-1:0] c_row_addr;
    logic              reading;
    logic              writing;
    logic              last_row;

    assign reading  = busy && (step < STEP_DRAIN);   // Steps 0..N-1
    assign writing  = busy && (step == STEP_WRITE);
    assign last_row = (row == ROW_LAST);

    ////////////////////////////////////////////////////////////////////////////
    // Row and step counters
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            row  <= '0;
            step <= '0;
        end else if (!busy) begin
            if (start) begin
                busy <= 1'b1;
                row  <= '0;
                step <= '0;
            end
        end else if (writing) begin
            step <= '0;
            row  <= row + 1'b1;
            if (last_row) begin
                busy <= 1'b0;   // Falls right after the done cycle
            end
        end else begin
            step <= step + 1'b1;
        end
    end

    // Row addresses track cfg while idle so the first busy cycle is ready
    always_ff @(posedge clk) begin
        if (!busy) begin
            a_row_addr <= cfg.a_addr;
            b_row_addr <= cfg.b_addr;
            c_row_addr <= cfg.c_addr;
        end else if (writing) begin
            a_row_addr <= a_row_addr + cfg.a_stride;
            b_row_addr <= cfg.b_addr;   // B restarts at row 0
            c_row_addr <= c_row_addr + cfg.c_stride;
        end else if (reading) begin
            b_row_addr <= b_row_addr + cfg.b_stride;
        end
    end

    // k of the read issued last cycle, matches RAM latency
    always_ff @(posedge clk) begin
        k_sel <= step[KW-1:0];
    end

    assign addr0     = writing ? c_row_addr : a_row_addr;
    assign addr1     = b_row_addr;
    assign we0       = writing ? cfg.col_mask[N-1:0] : '0;
    assign acc_clear = busy && (step == '0);
    assign acc_en    = busy && (step != '0) && (step <= STEP_DRAIN);   // Steps 1..N

    assign status.busy       = busy;
    assign status.done_pulse = writing && last_row;

endmodule

// ==== tpu_lite_mac_row.sv ====
module tpu_lite_mac_row #(
    parameter int N = 4
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                acc_clear,
    input  logic                                acc_en,
    input  logic [$clog2(N)-1:0]                k_sel,
    input  logic [N*tpu_lite_pkg::DWIDTH-1:0]   a_row,
    input  logic [N*tpu_lite_pkg::DWIDTH-1:0]   b_row,
    output logic [N*tpu_lite_pkg::DWIDTH-1:0]   c_row
);
    import tpu_lite_pkg::*;

    localparam int PW    = 2 * DWIDTH;         // One product
    localparam int ACC_W = PW + $clog2(N);     // Sum of N products
    localparam logic [DWIDTH-1:0] SAT_MAX = '1;

    logic [DWIDTH-1:0] a_elem;

    // The same A element feeds every column in a given step
    assign a_elem = a_row[k_sel*DWIDTH +: DWIDTH];

    ////////////////////////////////////////////////////////////////////////////
    // One multiply-accumulate per column
    ////////////////////////////////////////////////////////////////////////////

    for (genvar j = 0; j < N; j++) begin : g_col
        logic [DWIDTH-1:0] b_elem;
        logic [PW-1:0]     prod;
        logic [ACC_W-1:0]  acc;
        logic              over;

        assign b_elem = b_row[j*DWIDTH +: DWIDTH];
        assign prod   = a_elem * b_elem;

        always_ff @(posedge clk) begin
            if (reset || acc_clear) begin
                acc <= '0;   // Clear wins over enable
            end else if (acc_en) begin
                acc <= acc + ACC_W'(prod);
            end
        end

        // Anything above the element range clamps to all ones
        assign over = (acc > ACC_W'(SAT_MAX));
        assign c_row[j*DWIDTH +: DWIDTH] = over ? SAT_MAX : acc[DWIDTH-1:0];
    end

endmodule

// ==== tpu_lite_top.sv ====
module tpu_lite_top #(
    parameter int N = 4
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  reg_wr,
    input  logic                                  reg_rd,
    input  logic [tpu_lite_pkg::REG_AWIDTH-1:0]   reg_addr,
    input  logic [tpu_lite_pkg::REG_DWIDTH-1:0]   reg_wdata,
    output logic [tpu_lite_pkg::REG_DWIDTH-1:0]   reg_rdata,
    input  logic [tpu_lite_pkg::AWIDTH-1:0]       host_addr,
    input  logic [N*tpu_lite_pkg::DWIDTH-1:0]     host_wdata,
    input  logic [N-1:0]                          host_we,
    output logic [N*tpu_lite_pkg::DWIDTH-1:0]     host_rdata
);
    import tpu_lite_pkg::*;

    mm_cfg_t             cfg;
    mm_status_t          status;
    logic                start;
    logic [AWIDTH-1:0]   addr0;
    logic [AWIDTH-1:0]   seq_addr1;
    logic [AWIDTH-1:0]   ram_addr1;
    logic [N-1:0]        we0;
    logic [N-1:0]        ram_we1;
    logic                acc_clear;
    logic                acc_en;
    logic [$clog2(N)-1:0] k_sel;
    logic [N*DWIDTH-1:0] q0;
    logic [N*DWIDTH-1:0] q1;
    logic [N*DWIDTH-1:0] c_row;

    ////////////////////////////////////////////////////////////////////////////
    // Port 1 belongs to the host unless the engine is running
    ////////////////////////////////////////////////////////////////////////////

    assign ram_addr1  = status.busy ? seq_addr1 : host_addr;
    assign ram_we1    = status.busy ? '0 : host_we;   // Host writes dropped while busy
    assign host_rdata = q1;

    tpu_lite_regs u_regs (
        .clk(clk), .reset(reset),
        .reg_wr(reg_wr), .reg_rd(reg_rd), .reg_addr(reg_addr),
        .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
        .cfg(cfg), .start(start), .status(status)
    );

    tpu_lite_ctrl #(.N(N)) u_ctrl (
        .clk(clk), .reset(reset), .start(start), .cfg(cfg), .status(status),
        .addr0(addr0), .addr1(seq_addr1), .we0(we0),
        .acc_clear(acc_clear), .acc_en(acc_en), .k_sel(k_sel)
    );

    tpu_lite_mac_row #(.N(N)) u_mac (
        .clk(clk), .reset(reset), .acc_clear(acc_clear), .acc_en(acc_en),
        .k_sel(k_sel), .a_row(q0), .b_row(q1), .c_row(c_row)
    );

    tpu_lite_ram #(.N(N)) u_ram (
        .clk(clk),
        .addr0(addr0), .d0(c_row), .we0(we0), .q0(q0),       // A reads, C writes
        .addr1(ram_addr1), .d1(host_wdata), .we1(ram_we1), .q1(q1)
    );

endmodule

// ==== tpu_lite_chk.sv ====
module tpu_lite_chk #(
    parameter int N = 4
) (
    input logic                     clk,
    input logic                     reset,
    input logic                     start,
    input tpu_lite_pkg::mm_status_t status,
    input logic [N-1:0]             we0,
    input logic                     acc_en
);

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer properties
    ////////////////////////////////////////////////////////////////////////////

    // Done is a single cycle and busy is gone right after it
    done_single: assert property (
        @(posedge clk) disable iff (reset)
        status.done_pulse |=> (!status.done_pulse && !status.busy)
    ) else $error("done pulse lasted more than one cycle or busy stayed high after it");

    // The C write never overlaps accumulation
    write_not_accumulating: assert property (
        @(posedge clk) disable iff (reset)
        acc_en |-> (we0 == '0)
    ) else $error("C write enable active while accumulating");

    // A start during a run leaves the run alone
    start_while_busy: assert property (
        @(posedge clk) disable iff (reset)
        (start && status.busy) |=> status.busy
    ) else $error("start during a run dropped busy");

endmodule

bind tpu_lite_ctrl tpu_lite_chk #(.N(N)) u_chk (
    .clk(clk),
    .reset(reset),
    .start(start),
    .status(status),
    .we0(we0),
    .acc_en(acc_en)
);

// ==== tb_tpu_lite.sv ====
module tb_tpu_lite;
    import tpu_lite_pkg::*;

    localparam int N          = 4;
    localparam int ROW_W      = N * DWIDTH;
    localparam int DEPTH      = 1 << AWIDTH;
    localparam int AMASK      = DEPTH - 1;
    localparam int PERIOD     = 100;
    localparam int DRIVE      = 10;                // Input delay after the edge
    localparam int RUN_CYCLES = N * (N + 2) + 1;   // Start write to done pulse
    localparam int MAX_CYCLES = 3000;
    localparam logic [31:0] ADDR_FIELD = 32'((1 << AWIDTH) - 1);

    logic                  clk;
    logic                  reset;
    logic                  reg_wr;
    logic                  reg_rd;
    logic [REG_AWIDTH-1:0] reg_addr;
    logic [REG_DWIDTH-1:0] reg_wdata;
    logic [REG_DWIDTH-1:0] reg_rdata;
    logic [AWIDTH-1:0]     host_addr;
    logic [ROW_W-1:0]      host_wdata;
    logic [N-1:0]          host_we;
    logic [ROW_W-1:0]      host_rdata;

    logic [DWIDTH-1:0] shadow [DEPTH];   // Reference copy of the RAM
    int                cycle_count = 0;

    tpu_lite_top #(.N(N)) DUT (
        .clk(clk), .reset(reset),
        .reg_wr(reg_wr), .reg_rd(reg_rd), .reg_addr(reg_addr),
        .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
        .host_addr(host_addr), .host_wdata(host_wdata),
        .host_we(host_we), .host_rdata(host_rdata)
    );

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            fail_run($sformatf("Timeout: the run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reporting and bus helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] expected);
        assert (got === expected) else begin
            fail_run($sformatf("CHECK FAILED at time %0t: %s, got 0x%0h, expected 0x%0h",
                               $time, what, got, expected));
        end
    endtask

    task automatic reg_write(input logic [REG_AWIDTH-1:0] addr, input logic [31:0] data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(posedge clk);
        #DRIVE;
        reg_wr = 1'b0;
    endtask

    task automatic check_reg(input logic [REG_AWIDTH-1:0] addr, input logic [31:0] expected,
                             input string what);
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(posedge clk);
        #DRIVE;
        reg_rd = 1'b0;
        check_value(what, 64'(reg_rdata), 64'(expected));   // Registered read data
    endtask

    task automatic host_write(input int addr, input logic [ROW_W-1:0] data,
                              input logic [N-1:0] we);
        host_addr  = AWIDTH'(addr);
        host_wdata = data;
        host_we    = we;
        for (int i = 0; i < N; i++) begin
            if (we[i]) begin
                shadow[(addr + i) & AMASK] = data[i*DWIDTH +: DWIDTH];
            end
        end
        @(posedge clk);
        #DRIVE;
        host_we = '0;
    endtask

    task automatic host_read(input int addr, output logic [ROW_W-1:0] data);
        host_addr = AWIDTH'(addr);
        @(posedge clk);
        #DRIVE;
        data = host_rdata;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic int row_addr(input logic [AWIDTH-1:0] base,
                                    input logic [AWIDTH-1:0] stride, input int i);
        return (int'(base) + i * int'(stride)) & AMASK;
    endfunction

    function automatic logic [ROW_W-1:0] shadow_row(input int addr);
        logic [ROW_W-1:0] row;
        for (int i = 0; i < N; i++) begin
            row[i*DWIDTH +: DWIDTH] = shadow[(addr + i) & AMASK];
        end
        return row;
    endfunction

    // A quarter of the elements span the full range, the rest stay small
    function automatic logic [ROW_W-1:0] random_row(input bit mixed);
        logic [ROW_W-1:0] row;
        for (int i = 0; i < N; i++) begin
            if (!mixed || $urandom_range(0, 3) == 0) begin
                row[i*DWIDTH +: DWIDTH] = 8'($urandom_range(0, 255));
            end else begin
                row[i*DWIDTH +: DWIDTH] = 8'($urandom_range(0, 7));
            end
        end
        return row;
    endfunction

    // Sums are all formed before C is written back
    task automatic compute_expected(input mm_cfg_t cfg);
        int unsigned       sum;
        logic [DWIDTH-1:0] result [N][N];
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                sum = 0;
                for (int k = 0; k < N; k++) begin
                    sum = sum + int'(shadow[(row_addr(cfg.a_addr, cfg.a_stride, i) + k) & AMASK])
                              * int'(shadow[(row_addr(cfg.b_addr, cfg.b_stride, k) + j) & AMASK]);
                end
                result[i][j] = (sum > 255) ? 8'hFF : 8'(sum);   // Saturate
            end
        end
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                if (cfg.col_mask[j]) begin
                    shadow[(row_addr(cfg.c_addr, cfg.c_stride, i) + j) & AMASK] = result[i][j];
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_row(input int addr);
        logic [ROW_W-1:0] got;
        host_read(addr, got);
        check_value($sformatf("RAM row at %0d", addr), 64'(got), 64'(shadow_row(addr)));
    endtask

    task automatic fill_memory();
        logic [ROW_W-1:0] row;
        for (int a = 0; a < DEPTH; a += N) begin
            for (int i = 0; i < N; i++) begin
                row[i*DWIDTH +: DWIDTH] = 8'((a + i) ^ ((a + i) >> 5) ^ 8'h5A);
            end
            host_write(a, row, '1);
        end
    endtask

    // Kind 0 loads the identity, 1 full range values, 2 mixed values
    task automatic load_matrix(input logic [AWIDTH-1:0] base,
                               input logic [AWIDTH-1:0] stride, input int kind);
        logic [ROW_W-1:0] row;
        for (int i = 0; i < N; i++) begin
            if (kind == 0) begin
                row = '0;
                row[i*DWIDTH +: DWIDTH] = 8'd1;
            end else begin
                row = random_row(kind == 2);
            end
            host_write(row_addr(base, stride, i), row, '1);
        end
    endtask

    task automatic configure(input mm_cfg_t cfg);
        reg_write(REG_A_ADDR, 32'(cfg.a_addr));
        reg_write(REG_B_ADDR, 32'(cfg.b_addr));
        reg_write(REG_C_ADDR, 32'(cfg.c_addr));
        reg_write(REG_A_STRIDE, 32'(cfg.a_stride));
        reg_write(REG_B_STRIDE, 32'(cfg.b_stride));
        reg_write(REG_C_STRIDE, 32'(cfg.c_stride));
        reg_write(REG_COL_MASK, cfg.col_mask);
    endtask

    // Counts cycles from the start write up to the done pulse
    task automatic run_engine(input bit disturb, input int poke_addr,
                              input logic [ROW_W-1:0] poke_data, output int cycles);
        reg_wr    = 1'b1;
        reg_addr  = REG_CTRL;
        reg_wdata = 32'h1;
        cycles    = 0;
        do begin
            @(posedge clk);
            #DRIVE;
            cycles++;
            reg_wr  = 1'b0;
            reg_rd  = 1'b0;
            host_we = '0;
            if (disturb && cycles == 1) begin   // Second start meets busy rising
                reg_wr = 1'b1;
            end
            if (disturb && cycles == 3) begin
                reg_rd   = 1'b1;
                reg_addr = REG_STATUS;
            end
            if (disturb && cycles == 4) begin
                check_value("status while busy", 64'(reg_rdata), 64'(32'h1));
            end
            if (disturb && cycles == 5) begin   // Engine is busy here
                reg_wr     = 1'b1;
                reg_addr   = REG_CTRL;
                host_addr  = AWIDTH'(poke_addr);
                host_wdata = poke_data;
                host_we    = '1;
            end
        end while (!DUT.status.done_pulse);
        @(posedge clk);   // Busy falls, port 1 returns to the host
        #DRIVE;
    endtask

    task automatic check_c_rows(input mm_cfg_t cfg);
        for (int i = 0; i < N; i++) begin
            check_row(row_addr(cfg.c_addr, cfg.c_stride, i));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_cfg_reg(input logic [REG_AWIDTH-1:0] addr, input logic [31:0] field);
        logic [31:0] value;
        value = $urandom();
        reg_write(addr, value);
        check_reg(addr, value & field, $sformatf("register 0x%0h readback", addr));
    endtask

    task automatic test_registers();
        check_reg(REG_STATUS, 32'h0, "status after reset");
        check_cfg_reg(REG_A_ADDR, ADDR_FIELD);
        check_cfg_reg(REG_B_ADDR, ADDR_FIELD);
        check_cfg_reg(REG_C_ADDR, ADDR_FIELD);
        check_cfg_reg(REG_A_STRIDE, ADDR_FIELD);
        check_cfg_reg(REG_B_STRIDE, ADDR_FIELD);
        check_cfg_reg(REG_C_STRIDE, ADDR_FIELD);
        check_cfg_reg(REG_COL_MASK, 32'hFFFF_FFFF);
        check_reg(8'h24, 32'h0, "unmapped offset 0x24");
        check_reg(8'h80, 32'h0, "unmapped offset 0x80");
        check_reg(8'hFC, 32'h0, "unmapped offset 0xFC");
    endtask

    task automatic test_host_memory();
        host_write(201, random_row(1'b0), '1);
        host_write(203, random_row(1'b0), N'(32'h5555_5555));
        host_write(206, random_row(1'b0), N'(32'hAAAA_AAAA));
        host_write(1022, random_row(1'b0), '1);   // Wraps to the bottom
        host_write(1023, random_row(1'b0), N'(32'h6));
        for (int a = 199; a < 212; a++) begin
            check_row(a);
        end
        check_row(1020);
        check_row(1023);
    endtask

    task automatic test_identity();
        mm_cfg_t          cfg;
        int               cycles;
        logic [ROW_W-1:0] got;
        cfg = '{a_addr: 10'd0, b_addr: 10'd64, c_addr: 10'd128,
                a_stride: AWIDTH'(N), b_stride: AWIDTH'(N), c_stride: AWIDTH'(N),
                col_mask: '1};
        load_matrix(cfg.a_addr, cfg.a_stride, 0);
        load_matrix(cfg.b_addr, cfg.b_stride, 1);
        configure(cfg);
        run_engine(1'b0, 0, '0, cycles);
        check_value("identity done timing", 64'(cycles), 64'(RUN_CYCLES));
        check_reg(REG_STATUS, 32'h2, "status after identity run");
        compute_expected(cfg);
        for (int i = 0; i < N; i++) begin
            host_read(row_addr(cfg.c_addr, cfg.c_stride, i), got);
            check_value($sformatf("C row %0d equals B row", i), 64'(got),
                        64'(shadow_row(row_addr(cfg.b_addr, cfg.b_stride, i))));
        end
    endtask

    task automatic test_random_strides();
        mm_cfg_t cfg;
        int      cycles;
        cfg.a_addr   = AWIDTH'(100 + $urandom_range(0, 3));
        cfg.a_stride = AWIDTH'(N + 1 + $urandom_range(0, 6));
        cfg.b_addr   = AWIDTH'(300 + $urandom_range(0, 3));
        cfg.b_stride = AWIDTH'(N + 1 + $urandom_range(0, 6));
        cfg.c_addr   = AWIDTH'(1000);
        cfg.c_stride = AWIDTH'(N + 5);   // C runs past the top
        cfg.col_mask = '1;
        load_matrix(cfg.a_addr, cfg.a_stride, 2);
        load_matrix(cfg.b_addr, cfg.b_stride, 2);
        configure(cfg);
        run_engine(1'b0, 0, '0, cycles);
        check_value("strided done timing", 64'(cycles), 64'(RUN_CYCLES));
        compute_expected(cfg);
        check_c_rows(cfg);
    endtask

    task automatic test_column_mask();
        mm_cfg_t cfg;
        int      cycles;
        cfg = '{a_addr: 10'd400, b_addr: 10'd450, c_addr: 10'd500,
                a_stride: AWIDTH'(N), b_stride: AWIDTH'(N), c_stride: AWIDTH'(N + 2),
                col_mask: 32'hFFFF_FF55};   // Upper bits beyond N are ignored
        load_matrix(cfg.a_addr, cfg.a_stride, 2);
        load_matrix(cfg.b_addr, cfg.b_stride, 2);
        for (int i = 0; i < N; i++) begin
            host_write(row_addr(cfg.c_addr, cfg.c_stride, i), {N{8'hEE}}, '1);
        end
        configure(cfg);
        run_engine(1'b0, 0, '0, cycles);
        compute_expected(cfg);
        check_c_rows(cfg);
    endtask

    task automatic test_control();
        mm_cfg_t cfg;
        int      cycles;
        int      poke;
        cfg = '{a_addr: 10'd600, b_addr: 10'd650, c_addr: 10'd700,
                a_stride: AWIDTH'(N), b_stride: AWIDTH'(N), c_stride: AWIDTH'(N),
                col_mask: '1};
        load_matrix(cfg.a_addr, cfg.a_stride, 2);
        load_matrix(cfg.b_addr, cfg.b_stride, 2);
        configure(cfg);
        reg_write(REG_STATUS, 32'h2);   // Drop done left by the earlier runs
        check_reg(REG_STATUS, 32'h0, "status cleared before disturbed run");
        poke = row_addr(cfg.b_addr, cfg.b_stride, 0);
        run_engine(1'b1, poke, ~shadow_row(poke), cycles);
        check_value("done timing with second start", 64'(cycles), 64'(RUN_CYCLES));
        check_reg(REG_STATUS, 32'h2, "status after disturbed run");
        for (int i = 0; i < N; i++) begin
            check_row(row_addr(cfg.b_addr, cfg.b_stride, i));   // Host writes dropped
        end
        compute_expected(cfg);
        check_c_rows(cfg);
        reg_write(REG_STATUS, 32'h2);
        check_reg(REG_STATUS, 32'h0, "status after done clear");
    endtask

    initial begin
        void'($urandom(32'h3d61dd5a));
        reset      = 1'b1;
        reg_wr     = 1'b0;
        reg_rd     = 1'b0;
        reg_addr   = '0;
        reg_wdata  = '0;
        host_addr  = '0;
        host_wdata = '0;
        host_we    = '0;
        repeat (8) @(posedge clk);
        #DRIVE;
        reset = 1'b0;

        test_registers();
        fill_memory();
        test_host_memory();
        test_identity();
        test_random_strides();
        test_column_mask();
        test_control();

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== tpu_lite.f ====
tpu_lite_pkg.sv
tpu_lite_ram.sv
tpu_lite_regs.sv
tpu_lite_ctrl.sv
tpu_lite_mac_row.sv
tpu_lite_top.sv
tpu_lite_chk.sv
tb_tpu_lite.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the tpu_lite testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_tpu_lite \
    -f tpu_lite.f

# The simulation output decides the result
output=$(./obj_dir/Vtb_tpu_lite 2>&1) || true
echo "$output"

grep -qx "=== PASS ===" <<< "$output"
echo "Simulation passed"
